//--- Makefile
TOP := voxel_csr_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+design
design/voxel_csr_pkg.sv
design/csr_bus_front.sv
design/view_regs.sv
design/event_regs.sv
design/voxel_csr_top.sv
sim/voxel_csr_sva.sv
sim/voxel_csr_tb.sv

//--- design/csr_bus_front.sv
`timescale 1ns/1ps
`include "voxel_csr_config.svh"

module csr_bus_front
    import voxel_csr_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic [`CSR_ADDR_W-1:0]   s_axil_awaddr,
    input  logic                     s_axil_awvalid,
    output logic                     s_axil_awready,
    input  logic [`CSR_DATA_W-1:0]   s_axil_wdata,
    input  logic [`CSR_DATA_W/8-1:0] s_axil_wstrb,
    input  logic                     s_axil_wvalid,
    output logic                     s_axil_wready,
    output logic [1:0]               s_axil_bresp,
    output logic                     s_axil_bvalid,
    input  logic                     s_axil_bready,
    input  logic [`CSR_ADDR_W-1:0]   s_axil_araddr,
    input  logic                     s_axil_arvalid,
    output logic                     s_axil_arready,
    output logic [`CSR_DATA_W-1:0]   s_axil_rdata,
    output logic [1:0]               s_axil_rresp,
    output logic                     s_axil_rvalid,
    input  logic                     s_axil_rready,

    output csr_wr_t                  wr,
    output csr_rd_t                  rd,
    input  csr_rsp_t                 view_rsp,
    input  csr_rsp_t                 event_rsp
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic                   wr_fire;
    logic                   rd_fire;
    logic [`CSR_DATA_W-1:0] rd_sel;

    assign wr_fire = s_axil_awvalid && s_axil_awready &&
                     s_axil_wvalid  && s_axil_wready  && !s_axil_bvalid;
    assign rd_fire = s_axil_arvalid && s_axil_arready && !s_axil_rvalid;

    // ============================================================
    // strobes to the register banks
    // ============================================================
    assign wr.valid = wr_fire;
    assign wr.word  = s_axil_awaddr[`CSR_WORD_W+1:2]; // byte lanes dropped
    assign wr.data  = s_axil_wdata;
    assign wr.strb  = s_axil_wstrb;

    assign rd.valid = rd_fire;
    assign rd.word  = s_axil_araddr[`CSR_WORD_W+1:2];

    // event bank first, then view bank, else zero
    always_comb begin
        if (event_rsp.hit) begin
            rd_sel = event_rsp.data;
        end else if (view_rsp.hit) begin
            rd_sel = view_rsp.data;
        end else begin
            rd_sel = '0;
        end
    end

    assign s_axil_bresp = RESP_OKAY; // every word answers OKAY
    assign s_axil_rresp = RESP_OKAY;

    // ============================================================
    // write channel
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
        end else begin
            if (!s_axil_awready)
                s_axil_awready <= s_axil_awvalid;
            if (!s_axil_wready)
                s_axil_wready <= s_axil_wvalid;

            if (wr_fire) begin
                s_axil_bvalid  <= 1'b1;
                s_axil_awready <= 1'b0;
                s_axil_wready  <= 1'b0;
            end else if (s_axil_bvalid && s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
        end
    end

    // ============================================================
    // read channel
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
        end else begin
            if (!s_axil_arready)
                s_axil_arready <= s_axil_arvalid;

            if (rd_fire) begin
                s_axil_rvalid  <= 1'b1;
                s_axil_arready <= 1'b0;
            end else if (s_axil_rvalid && s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire)
            s_axil_rdata <= rd_sel; // held while rvalid waits
    end

endmodule

//--- design/event_regs.sv
`timescale 1ns/1ps
`include "voxel_csr_config.svh"

module event_regs
    import voxel_csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  csr_wr_t  wr,
    input  csr_rd_t  rd,
    input  logic     frame_done_pulse,
    input  logic     core_busy,
    output csr_rsp_t rsp,
    output logic     soft_reset_pulse,
    output logic     start_frame_pulse,
    output logic     irq_out
);

    logic [`IRQ_W-1:0] int_status;
    logic [`IRQ_W-1:0] int_status_nxt;
    logic [`IRQ_W-1:0] int_mask;
    logic              frame_latch;
    logic              frame_latch_nxt;
    logic              wr_ctrl;

    assign wr_ctrl = wr.valid && (wr.word == W_CTRL);
    assign irq_out = |(int_status & int_mask); // level irq

    // ============================================================
    // event and clear priority, last assignment wins
    // ============================================================
    always_comb begin
        int_status_nxt  = int_status;
        frame_latch_nxt = frame_latch;

        if (rd.valid && rd.word == W_STATUS)
            frame_latch_nxt = 1'b0; // clear on read
        if (frame_done_pulse) begin
            frame_latch_nxt   = 1'b1;
            int_status_nxt[0] = 1'b1;
        end

        if (wr_ctrl && wr.data[1]) begin
            frame_latch_nxt   = 1'b0; // new frame
            int_status_nxt[0] = 1'b0;
        end
        if (wr.valid && wr.word == W_INT_STATUS)
            int_status_nxt = int_status_nxt & ~wr.data[`IRQ_W-1:0]; // w1c
        if (wr.valid && wr.word == W_IRQ_TEST && wr.data[0])
            int_status_nxt[3] = 1'b1;

        // deferred clear, one cycle after the soft reset command
        if (soft_reset_pulse) begin
            int_status_nxt  = '0;
            frame_latch_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_status        <= '0;
            int_mask          <= '0;
            frame_latch       <= 1'b0;
            soft_reset_pulse  <= 1'b0;
            start_frame_pulse <= 1'b0;
        end else begin
            int_status        <= int_status_nxt;
            frame_latch       <= frame_latch_nxt;
            soft_reset_pulse  <= wr_ctrl && wr.data[0];
            start_frame_pulse <= wr_ctrl && wr.data[1];
            if (wr.valid && wr.word == W_INT_MASK)
                int_mask <= wr.data[`IRQ_W-1:0];
        end
    end

    // ============================================================
    // read decode
    // ============================================================
    always_comb begin
        rsp = '0;
        if (rd.valid) begin
            rsp.hit = 1'b1;
            case (rd.word)
                W_ID:         rsp.data = {`VENDOR_ID, `DEVICE_ID};
                W_REV:        rsp.data = {{(`CSR_DATA_W-16){1'b0}}, `BUILD_ID, `REV_ID};
                W_STATUS:     rsp.data = {{(`CSR_DATA_W-2){1'b0}}, frame_latch, core_busy};
                W_INT_STATUS: rsp.data = {{(`CSR_DATA_W-`IRQ_W){1'b0}}, int_status};
                W_INT_MASK:   rsp.data = {{(`CSR_DATA_W-`IRQ_W){1'b0}}, int_mask};
                default:      rsp.hit  = 1'b0;
            endcase
        end
    end

endmodule

//--- design/view_regs.sv
`timescale 1ns/1ps
`include "voxel_csr_config.svh"

module view_regs
    import voxel_csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  csr_wr_t                wr,
    input  csr_rd_t                rd,
    input  logic                   soft_reset_pulse,
    output csr_rsp_t               rsp,
    output cam_t                   cam,
    output logic                   cam_load_pulse,
    output flags_t                 flags,
    output logic                   flags_load_pulse,
    output sel_t                   sel,
    output logic                   sel_load_pulse,
    output logic [`CSR_DATA_W-1:0] fb_base,
    output logic [`CSR_DATA_W-1:0] fb_stride
);

    localparam flags_t FLAGS_RST = 4'b0011; // smooth and curvature on

    logic wr_cam;
    logic wr_sel;
    logic wr_flags;

    function automatic logic [`CSR_DATA_W-1:0] merge_bytes(
        input logic [`CSR_DATA_W-1:0]   cur,
        input logic [`CSR_DATA_W-1:0]   data,
        input logic [`CSR_DATA_W/8-1:0] strb
    );
        logic [`CSR_DATA_W-1:0] res;
        res = cur;
        for (int i = 0; i < `CSR_DATA_W/8; i++) begin
            if (strb[i])
                res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [`CSR_DATA_W-1:0] sext(input logic signed [`COORD_W-1:0] v);
        return {{(`CSR_DATA_W-`COORD_W){v[`COORD_W-1]}}, v};
    endfunction

    function automatic logic [`CSR_DATA_W-1:0] zext(input logic [`SEL_W-1:0] v);
        return {{(`CSR_DATA_W-`SEL_W){1'b0}}, v};
    endfunction

    assign wr_cam   = wr.valid && (wr.word inside {[W_CAM_X:W_CAM_PLANE_Y]});
    assign wr_sel   = wr.valid && (wr.word inside {[W_SEL_ACTIVE:W_SEL_Z]});
    assign wr_flags = wr.valid && ((wr.word == W_FLAGS) ||
                                   (wr.word == W_CTRL && |wr.data[3:2]));

    // ============================================================
    // register writes
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cam              <= '0;
            flags            <= FLAGS_RST;
            sel              <= '0;
            fb_base          <= '0;
            fb_stride        <= '0;
            cam_load_pulse   <= 1'b0;
            flags_load_pulse <= 1'b0;
            sel_load_pulse   <= 1'b0;
        end else begin
            cam_load_pulse   <= wr_cam;
            flags_load_pulse <= wr_flags;
            sel_load_pulse   <= wr_sel;

            if (soft_reset_pulse)
                flags <= FLAGS_RST;

            if (wr.valid) begin
                case (wr.word)
                    W_CAM_X:       cam.pos_x   <= wr.data[`COORD_W-1:0];
                    W_CAM_Y:       cam.pos_y   <= wr.data[`COORD_W-1:0];
                    W_CAM_Z:       cam.pos_z   <= wr.data[`COORD_W-1:0];
                    W_CAM_DIR_X:   cam.dir_x   <= wr.data[`COORD_W-1:0];
                    W_CAM_DIR_Y:   cam.dir_y   <= wr.data[`COORD_W-1:0];
                    W_CAM_DIR_Z:   cam.dir_z   <= wr.data[`COORD_W-1:0];
                    W_CAM_PLANE_X: cam.plane_x <= wr.data[`COORD_W-1:0];
                    W_CAM_PLANE_Y: cam.plane_y <= wr.data[`COORD_W-1:0];
                    W_FLAGS:       flags       <= wr.data[3:0];
                    W_CTRL: begin
                        if (|wr.data[3:2]) begin
                            flags.diag_slice  <= wr.data[2]; // ctrl order differs from FLAGS
                            flags.extra_light <= wr.data[3];
                        end
                    end
                    W_SEL_ACTIVE:  sel.active  <= wr.data[0];
                    W_SEL_X:       sel.x       <= wr.data[`SEL_W-1:0];
                    W_SEL_Y:       sel.y       <= wr.data[`SEL_W-1:0];
                    W_SEL_Z:       sel.z       <= wr.data[`SEL_W-1:0];
                    W_FB_BASE:     fb_base     <= merge_bytes(fb_base, wr.data, wr.strb);
                    W_FB_STRIDE:   fb_stride   <= merge_bytes(fb_stride, wr.data, wr.strb);
                    default: ;
                endcase
            end
        end
    end

    // ============================================================
    // read decode
    // ============================================================
    always_comb begin
        rsp = '0;
        if (rd.valid) begin
            rsp.hit = 1'b1;
            case (rd.word)
                W_CTRL:        rsp.data = {{(`CSR_DATA_W-4){1'b0}},
                                           flags.extra_light, flags.diag_slice, 2'b00};
                W_CAM_X:       rsp.data = sext(cam.pos_x);
                W_CAM_Y:       rsp.data = sext(cam.pos_y);
                W_CAM_Z:       rsp.data = sext(cam.pos_z);
                W_CAM_DIR_X:   rsp.data = sext(cam.dir_x);
                W_CAM_DIR_Y:   rsp.data = sext(cam.dir_y);
                W_CAM_DIR_Z:   rsp.data = sext(cam.dir_z);
                W_CAM_PLANE_X: rsp.data = sext(cam.plane_x);
                W_CAM_PLANE_Y: rsp.data = sext(cam.plane_y);
                W_FLAGS:       rsp.data = {{(`CSR_DATA_W-4){1'b0}}, flags};
                W_SEL_ACTIVE:  rsp.data = {{(`CSR_DATA_W-1){1'b0}}, sel.active};
                W_SEL_X:       rsp.data = zext(sel.x);
                W_SEL_Y:       rsp.data = zext(sel.y);
                W_SEL_Z:       rsp.data = zext(sel.z);
                W_FB_BASE:     rsp.data = fb_base;
                W_FB_STRIDE:   rsp.data = fb_stride;
                default:       rsp.hit  = 1'b0; // not a view word
            endcase
        end
    end

endmodule

//--- design/voxel_csr_config.svh
`ifndef VOXEL_CSR_CONFIG_SVH
`define VOXEL_CSR_CONFIG_SVH

// ============================================================
// bus geometry
// ============================================================
`define CSR_ADDR_W 16 // byte address
`define CSR_DATA_W 32
`define CSR_WORD_W 8  // word index from addr[9:2]

// ============================================================
// datapath widths
// ============================================================
`define COORD_W 16 // signed camera coordinate
`define SEL_W   6
`define IRQ_W   4

// ============================================================
// identification
// ============================================================
`define VENDOR_ID 16'h1BAD
`define DEVICE_ID 16'h2024
`define REV_ID    8'h02
`define BUILD_ID  8'h01

`endif

//--- design/voxel_csr_pkg.sv
`include "voxel_csr_config.svh"

package voxel_csr_pkg;

    // word offsets, byte address >> 2
    typedef enum logic [`CSR_WORD_W-1:0] {
        W_ID          = 8'h00,
        W_REV         = 8'h01,
        W_CTRL        = 8'h04,
        W_STATUS      = 8'h05,
        W_CAM_X       = 8'h08,
        W_CAM_Y       = 8'h09,
        W_CAM_Z       = 8'h0A,
        W_CAM_DIR_X   = 8'h0B,
        W_CAM_DIR_Y   = 8'h0C,
        W_CAM_DIR_Z   = 8'h0D,
        W_CAM_PLANE_X = 8'h0E,
        W_CAM_PLANE_Y = 8'h0F,
        W_FLAGS       = 8'h10,
        W_SEL_ACTIVE  = 8'h11,
        W_SEL_X       = 8'h12,
        W_SEL_Y       = 8'h13,
        W_SEL_Z       = 8'h14,
        W_FB_BASE     = 8'h15,
        W_FB_STRIDE   = 8'h16,
        W_INT_STATUS  = 8'h20,
        W_INT_MASK    = 8'h21,
        W_IRQ_TEST    = 8'h22
    } csr_word_e;

    typedef struct packed {
        logic                     valid;
        logic [`CSR_WORD_W-1:0]   word;
        logic [`CSR_DATA_W-1:0]   data;
        logic [`CSR_DATA_W/8-1:0] strb;
    } csr_wr_t;

    typedef struct packed {
        logic                   valid;
        logic [`CSR_WORD_W-1:0] word;
    } csr_rd_t;

    typedef struct packed {
        logic                   hit;
        logic [`CSR_DATA_W-1:0] data;
    } csr_rsp_t;

    typedef struct packed {
        logic signed [`COORD_W-1:0] pos_x;
        logic signed [`COORD_W-1:0] pos_y;
        logic signed [`COORD_W-1:0] pos_z;
        logic signed [`COORD_W-1:0] dir_x;
        logic signed [`COORD_W-1:0] dir_y;
        logic signed [`COORD_W-1:0] dir_z;
        logic signed [`COORD_W-1:0] plane_x;
        logic signed [`COORD_W-1:0] plane_y;
    } cam_t;

    // bit order matches the FLAGS word
    typedef struct packed {
        logic diag_slice;  // bit 3
        logic extra_light; // bit 2
        logic curvature;
        logic smooth;      // bit 0
    } flags_t;

    typedef struct packed {
        logic              active;
        logic [`SEL_W-1:0] x;
        logic [`SEL_W-1:0] y;
        logic [`SEL_W-1:0] z;
    } sel_t;

endpackage

//--- design/voxel_csr_top.sv
`timescale 1ns/1ps
`include "voxel_csr_config.svh"

module voxel_csr_top
    import voxel_csr_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic [`CSR_ADDR_W-1:0]   s_axil_awaddr,
    input  logic                     s_axil_awvalid,
    output logic                     s_axil_awready,
    input  logic [`CSR_DATA_W-1:0]   s_axil_wdata,
    input  logic [`CSR_DATA_W/8-1:0] s_axil_wstrb,
    input  logic                     s_axil_wvalid,
    output logic                     s_axil_wready,
    output logic [1:0]               s_axil_bresp,
    output logic                     s_axil_bvalid,
    input  logic                     s_axil_bready,
    input  logic [`CSR_ADDR_W-1:0]   s_axil_araddr,
    input  logic                     s_axil_arvalid,
    output logic                     s_axil_arready,
    output logic [`CSR_DATA_W-1:0]   s_axil_rdata,
    output logic [1:0]               s_axil_rresp,
    output logic                     s_axil_rvalid,
    input  logic                     s_axil_rready,

    output cam_t                     cam,
    output logic                     cam_load_pulse,
    output flags_t                   flags,
    output logic                     flags_load_pulse,
    output sel_t                     sel,
    output logic                     sel_load_pulse,
    output logic                     soft_reset_pulse,
    output logic                     start_frame_pulse,
    output logic [`CSR_DATA_W-1:0]   fb_base,
    output logic [`CSR_DATA_W-1:0]   fb_stride,
    output logic                     irq_out,

    input  logic                     frame_done_pulse,
    input  logic                     core_busy
);

    csr_wr_t  wr;
    csr_rd_t  rd;
    csr_rsp_t view_rsp;
    csr_rsp_t event_rsp;

    csr_bus_front u_front (.*); // axi-lite ports match by name

    view_regs u_view (
        .clk, .rst_n, .wr, .rd, .soft_reset_pulse,
        .rsp (view_rsp),
        .cam, .cam_load_pulse, .flags, .flags_load_pulse,
        .sel, .sel_load_pulse, .fb_base, .fb_stride
    );

    event_regs u_event (
        .clk, .rst_n, .wr, .rd, .frame_done_pulse, .core_busy,
        .rsp (event_rsp),
        .soft_reset_pulse, .start_frame_pulse, .irq_out
    );

endmodule

//--- sim/voxel_csr_sva.sv
`timescale 1ns/1ps

module voxel_csr_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        cam_load_pulse,
    input logic        flags_load_pulse,
    input logic        sel_load_pulse,
    input logic        irq_out
);

    // ============================================================
    // response hold under back-pressure
    // ============================================================
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped without bready");
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata)) else $error("read response changed");

    // ============================================================
    // load pulses
    // ============================================================
    a_cam_one: assert property (@(posedge clk) disable iff (!rst_n)
        cam_load_pulse |=> !cam_load_pulse) else $error("cam_load_pulse too long");
    a_flags_one: assert property (@(posedge clk) disable iff (!rst_n)
        flags_load_pulse |=> !flags_load_pulse) else $error("flags_load_pulse too long");
    a_sel_one: assert property (@(posedge clk) disable iff (!rst_n)
        sel_load_pulse |=> !sel_load_pulse) else $error("sel_load_pulse too long");
    a_load_with_b: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cam_load_pulse | flags_load_pulse | sel_load_pulse) |-> $rose(bvalid))
        else $error("load pulse without write response");

    a_irq_reset: assert property (@(posedge clk) !rst_n |-> !irq_out)
        else $error("irq_out high in reset");

endmodule

bind voxel_csr_top voxel_csr_sva u_sva (
    .clk, .rst_n,
    .bvalid (s_axil_bvalid), .bready (s_axil_bready),
    .rvalid (s_axil_rvalid), .rready (s_axil_rready), .rdata (s_axil_rdata),
    .cam_load_pulse, .flags_load_pulse, .sel_load_pulse, .irq_out
);

//--- sim/voxel_csr_tb.sv
`timescale 1ns/1ps
`include "voxel_csr_config.svh"

module voxel_csr_tb
    import voxel_csr_pkg::*;
();

    localparam int NUM_TESTS = 6;

    logic clk, rst_n;
    logic [15:0] s_axil_awaddr, s_axil_araddr;
    logic        s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic [31:0] s_axil_wdata, s_axil_rdata;
    logic [3:0]  s_axil_wstrb;
    logic [1:0]  s_axil_bresp, s_axil_rresp;
    logic        s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
    logic        s_axil_rvalid, s_axil_rready;
    cam_t        cam;
    flags_t      flags;
    sel_t        sel;
    logic        cam_load_pulse, flags_load_pulse, sel_load_pulse;
    logic        soft_reset_pulse, start_frame_pulse, irq_out;
    logic [31:0] fb_base, fb_stride;
    logic        frame_done_pulse, core_busy;

    logic [31:0] lcg_state = 32'h9fcf_0454;
    logic [4:0]  pulses; // cam, flags, sel, soft reset, start frame
    // shadow model
    logic [15:0] m_cam [8];
    logic [3:0]  m_flags = 4'b0011;
    logic [18:0] m_sel = '0;
    logic [31:0] m_fb [2];

    voxel_csr_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (2000 * NUM_TESTS) @(posedge clk);
        $display("timeout: a bus handshake never completed");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strb = 4'hF);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = 1'b1;
        @(posedge clk);
        #1;
        check_eq("s_axil_awready", 1, 32'(s_axil_awready));
        check_eq("s_axil_wready", 1, 32'(s_axil_wready));
        do begin
            @(posedge clk);
            #1;
        end while (!s_axil_bvalid);
        pulses = {cam_load_pulse, flags_load_pulse, sel_load_pulse,
                  soft_reset_pulse, start_frame_pulse};
        check_eq("s_axil_bresp", 32'd0, 32'(s_axil_bresp));
        check_eq("s_axil_awready", 0, 32'(s_axil_awready));
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        @(posedge clk);
        #1;
        check_eq("s_axil_arready", 1, 32'(s_axil_arready));
        do begin
            @(posedge clk);
            #1;
        end while (!s_axil_rvalid);
        data = s_axil_rdata;
        check_eq("s_axil_rresp", 32'd0, 32'(s_axil_rresp));
        s_axil_arvalid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic read_check(input string name, input logic [15:0] addr,
                              input logic [31:0] exp);
        logic [31:0] got;
        axil_read(addr, got);
        check_eq(name, exp, got);
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        logic [31:0] r, d, w;
        int          idx;
        rst_n = 1'b0;
        {s_axil_awaddr, s_axil_awvalid, s_axil_wdata, s_axil_wstrb, s_axil_wvalid} = '0;
        {s_axil_bready, s_axil_araddr, s_axil_arvalid, s_axil_rready} = '0;
        frame_done_pulse = 1'b0;
        core_busy        = 1'b0;
        foreach (m_cam[i]) m_cam[i] = '0;
        m_fb[0] = '0;
        m_fb[1] = '0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        // quiet bus after reset
        check_eq("s_axil_awready", 0, 32'(s_axil_awready));
        check_eq("s_axil_wready", 0, 32'(s_axil_wready));
        check_eq("s_axil_arready", 0, 32'(s_axil_arready));
        check_eq("s_axil_bvalid", 0, 32'(s_axil_bvalid));
        check_eq("s_axil_rvalid", 0, 32'(s_axil_rvalid));
        check_eq("irq_out", 0, 32'(irq_out));
        check_eq("flags", 32'(m_flags), 32'(flags));

        // ID words and an unmapped word
        read_check("ID", 16'h0000, 32'h1BAD2024);
        read_check("REV", 16'h0004, 32'h0000_0102);
        read_check("unmapped", 16'h00C0, 32'h0);

        // random view writes, every word once first
        for (int n = 0; n < 24; n++) begin
            idx = (n < 13) ? n : int'(lcg_next() % 13);
            d   = lcg_next();
            if (idx < 8) begin
                axil_write(16'((8 + idx) * 4), d);
                m_cam[idx] = d[15:0];
                check_eq("cam_load_pulse", 1, 32'(pulses[4]));
                read_check("cam word", 16'((8 + idx) * 4), {{16{d[15]}}, d[15:0]});
            end else if (idx < 12) begin
                w = 32'h11 + 32'(idx - 8);
                axil_write(16'(w * 4), d);
                case (idx)
                    8:  m_sel[18]    = d[0];
                    9:  m_sel[17:12] = d[5:0];
                    10: m_sel[11:6]  = d[5:0];
                    default: m_sel[5:0] = d[5:0];
                endcase
                check_eq("sel_load_pulse", 1, 32'(pulses[2]));
                read_check("sel word", 16'(w * 4), (idx == 8) ? {31'd0, d[0]} : {26'd0, d[5:0]});
            end else begin
                axil_write(16'h0040, d);
                m_flags = d[3:0];
                check_eq("flags_load_pulse", 1, 32'(pulses[3]));
                read_check("FLAGS", 16'h0040, {28'd0, d[3:0]});
            end
            check_eq("cam[127:96]", {m_cam[0], m_cam[1]}, cam[127:96]);
            check_eq("cam[95:64]", {m_cam[2], m_cam[3]}, cam[95:64]);
            check_eq("cam[63:32]", {m_cam[4], m_cam[5]}, cam[63:32]);
            check_eq("cam[31:0]", {m_cam[6], m_cam[7]}, cam[31:0]);
            check_eq("sel", 32'(m_sel), 32'(sel));
            check_eq("flags", 32'(m_flags), 32'(flags));
        end

        // byte merge on frame buffer words
        for (int n = 0; n < 8; n++) begin
            idx = n % 2;
            d   = lcg_next();
            r   = lcg_next();
            axil_write(16'(idx ? 16'h0058 : 16'h0054), d, r[3:0]);
            for (int b = 0; b < 4; b++)
                if (r[b]) m_fb[idx][8*b +: 8] = d[8*b +: 8];
            if (idx == 1) begin
                read_check("FB_STRIDE", 16'h0058, m_fb[1]);
                check_eq("fb_stride", m_fb[1], fb_stride);
            end else begin
                read_check("FB_BASE", 16'h0054, m_fb[0]);
                check_eq("fb_base", m_fb[0], fb_base);
            end
        end

        // frame done, status and interrupts
        core_busy        = 1'b1;
        frame_done_pulse = 1'b1;
        @(posedge clk);
        #1 frame_done_pulse = 1'b0;
        check_eq("irq_out", 0, 32'(irq_out));
        read_check("STATUS", 16'h0014, 32'h3);
        read_check("STATUS", 16'h0014, 32'h1);
        read_check("INT_STATUS", 16'h0080, 32'h1);
        axil_write(16'h0084, 32'h9);
        check_eq("irq_out", 1, 32'(irq_out));
        axil_write(16'h0088, 32'h1);
        read_check("INT_STATUS", 16'h0080, 32'h9);
        axil_write(16'h0080, 32'h8);
        read_check("INT_STATUS", 16'h0080, 32'h1);
        axil_write(16'h0080, 32'h1);
        check_eq("irq_out", 0, 32'(irq_out));
        core_busy = 1'b0;

        // control pulses and soft reset
        axil_write(16'h0010, 32'h2);
        check_eq("start_frame_pulse", 1, 32'(pulses[0]));
        axil_write(16'h0010, 32'h4);
        check_eq("flags_load_pulse", 1, 32'(pulses[3]));
        m_flags[3] = 1'b1;
        m_flags[2] = 1'b0;
        read_check("CTRL", 16'h0010, 32'h4);
        check_eq("flags", 32'(m_flags), 32'(flags));
        axil_write(16'h0088, 32'h1);
        axil_write(16'h0010, 32'h1);
        check_eq("soft_reset_pulse", 1, 32'(pulses[1]));
        read_check("FLAGS", 16'h0040, 32'h3);
        read_check("INT_STATUS", 16'h0080, 32'h0);

        // write back-pressure
        s_axil_awaddr  = 16'h0058;
        s_axil_wdata   = 32'hCAFE_0001;
        s_axil_wstrb   = 4'hF;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!s_axil_bvalid);
        s_axil_wdata = 32'hCAFE_0002; // second write waits
        repeat (5) begin
            @(posedge clk);
            #1;
            check_eq("s_axil_bvalid", 1, 32'(s_axil_bvalid));
            check_eq("fb_stride", 32'hCAFE_0001, fb_stride);
        end
        s_axil_bready = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (s_axil_bvalid);
        do begin
            @(posedge clk);
            #1;
        end while (!s_axil_bvalid);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        @(posedge clk);
        #1;
        check_eq("fb_stride", 32'hCAFE_0002, fb_stride);

        // read back-pressure
        s_axil_araddr  = 16'h0000;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!s_axil_rvalid);
        s_axil_araddr = 16'h0004;
        repeat (5) begin
            @(posedge clk);
            #1;
            check_eq("s_axil_rvalid", 1, 32'(s_axil_rvalid));
            check_eq("s_axil_rdata", 32'h1BAD2024, s_axil_rdata);
        end
        s_axil_rready = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (s_axil_rvalid);
        do begin
            @(posedge clk);
            #1;
        end while (!s_axil_rvalid);
        check_eq("s_axil_rdata", 32'h0000_0102, s_axil_rdata);
        s_axil_arvalid = 1'b0;
        @(posedge clk);
        #1;

        $display("PASS: all tests");
        $finish;
    end

endmodule
